//--- Makefile
# Verilator lint and simulation of the split L1 cache

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := tb_cache
FILELIST  := vlog.f
OBJDIR    := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- hdl/cache.sv
// ====================
// Split L1 cache top level
// Steers CPU port and shared memory port to I or D cache
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache #(
  parameter int ICACHE_ENTRIES_PER_WAY = `CACHE_ICACHE_SETS,
  parameter int DCACHE_ENTRIES_PER_WAY = `CACHE_DCACHE_SETS
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    is_instruction_i,
  // CPU side
  input  wire cache_pkg::addr_t  cpu_addr_i,
  input  wire cache_pkg::word_t  cpu_din_i,
  input  wire cache_pkg::wmask_t cpu_wmask_i,
  input  wire                    cpu_valid_i,
  output cache_pkg::word_t       cpu_dout_o,
  output logic                   cpu_ready_o,
  // Shared memory side
  output cache_pkg::addr_t       cache_addr_o,
  output cache_pkg::word_t       cache_din_o,
  output cache_pkg::wmask_t      cache_wmask_o,
  output logic                   cache_valid_o,
  input  wire cache_pkg::word_t  cache_dout_i,
  input  wire                    cache_ready_i
);
  import cache_pkg::*;

  // Instruction cache side
  logic  ic_cpu_valid;
  word_t ic_cpu_dout;
  logic  ic_cpu_ready;
  addr_t ic_ram_addr;
  logic  ic_ram_valid;
  logic  ic_ram_ready;

  // Data cache side
  logic   dc_cpu_valid;
  word_t  dc_cpu_dout;
  logic   dc_cpu_ready;
  addr_t  dc_ram_addr;
  wmask_t dc_ram_wmask;
  word_t  dc_ram_wdata;
  logic   dc_ram_valid;
  logic   dc_ram_ready;

  // Unselected cache sees valid and ready low
  assign ic_cpu_valid = cpu_valid_i && is_instruction_i;
  assign dc_cpu_valid = cpu_valid_i && !is_instruction_i;
  assign ic_ram_ready = cache_ready_i && is_instruction_i;
  assign dc_ram_ready = cache_ready_i && !is_instruction_i;

  // Return path and memory port mux
  always_comb begin
    if (is_instruction_i) begin
      cache_addr_o  = ic_ram_addr;
      // Instruction side only reads
      cache_din_o   = '0;
      cache_wmask_o = '0;
      cache_valid_o = ic_ram_valid;
      cpu_dout_o    = ic_cpu_dout;
      cpu_ready_o   = ic_cpu_ready;
    end else begin
      cache_addr_o  = dc_ram_addr;
      cache_din_o   = dc_ram_wdata;
      cache_wmask_o = dc_ram_wmask;
      cache_valid_o = dc_ram_valid;
      cpu_dout_o    = dc_cpu_dout;
      cpu_ready_o   = dc_cpu_ready;
    end
  end

  icache #(
    .ENTRIES_PER_WAY(ICACHE_ENTRIES_PER_WAY)
  ) u_icache (
    .clk        (clk),
    .rst_i      (rst_i),
    .cpu_addr_i (cpu_addr_i),
    .cpu_valid_i(ic_cpu_valid),
    .cpu_dout_o (ic_cpu_dout),
    .cpu_ready_o(ic_cpu_ready),
    .ram_addr_o (ic_ram_addr),
    .ram_rdata_i(cache_dout_i),
    .ram_valid_o(ic_ram_valid),
    .ram_ready_i(ic_ram_ready)
  );

  dcache #(
    .ENTRIES_PER_WAY(DCACHE_ENTRIES_PER_WAY)
  ) u_dcache (
    .clk        (clk),
    .rst_i      (rst_i),
    .cpu_addr_i (cpu_addr_i),
    .cpu_din_i  (cpu_din_i),
    .cpu_wmask_i(cpu_wmask_i),
    .cpu_valid_i(dc_cpu_valid),
    .cpu_dout_o (dc_cpu_dout),
    .cpu_ready_o(dc_cpu_ready),
    .ram_addr_o (dc_ram_addr),
    .ram_wmask_o(dc_ram_wmask),
    .ram_wdata_o(dc_ram_wdata),
    .ram_rdata_i(cache_dout_i),
    .ram_valid_o(dc_ram_valid),
    .ram_ready_i(dc_ram_ready)
  );

  // Steering may only change while the other cache is idle
  assert property (@(posedge clk) disable iff (rst_i)
    $rose(cache_valid_o) |->
      (is_instruction_i ? (u_dcache.state_q == IDLE) : (u_icache.state_q == IDLE)))
    else $error("memory request started while unselected cache busy");

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
// ====================
// Shared types for the split L1 cache
// Address, data and mask vectors, controller states
// ====================
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

  // Byte address on both CPU and memory sides
  typedef logic [`CACHE_XLEN-1:0] addr_t;
  // One data word, also the line size
  typedef logic [`CACHE_XLEN-1:0] word_t;
  // Byte write enables, zero means read
  typedef logic [`CACHE_XLEN/8-1:0] wmask_t;

  // Controller states, WRITE only reached in the data cache
  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, WRITE} cache_state_e;

endpackage

`default_nettype wire

//--- hdl/dcache.sv
// ====================
// Data cache, 2-way set-associative, write-through
// No write-allocate, byte-mask merge on write hit
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module dcache #(
  parameter int ENTRIES_PER_WAY = `CACHE_DCACHE_SETS
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire cache_pkg::addr_t  cpu_addr_i,
  input  wire cache_pkg::word_t  cpu_din_i,
  input  wire cache_pkg::wmask_t cpu_wmask_i,
  input  wire                    cpu_valid_i,
  output cache_pkg::word_t       cpu_dout_o,
  output logic                   cpu_ready_o,
  output cache_pkg::addr_t       ram_addr_o,
  output cache_pkg::wmask_t      ram_wmask_o,
  output cache_pkg::word_t       ram_wdata_o,
  input  wire cache_pkg::word_t  ram_rdata_i,
  output logic                   ram_valid_o,
  input  wire                    ram_ready_i
);
  import cache_pkg::*;

  localparam int IDX_W = $clog2(ENTRIES_PER_WAY);
  localparam int TAG_W = `CACHE_XLEN - IDX_W - 2;

  // Tag and data storage per way
  logic [TAG_W-1:0]           tag_q   [`CACHE_WAYS][ENTRIES_PER_WAY];
  word_t                      data_q  [`CACHE_WAYS][ENTRIES_PER_WAY];
  logic [ENTRIES_PER_WAY-1:0] valid_q [`CACHE_WAYS];
  // Per set, the way to replace next
  logic [ENTRIES_PER_WAY-1:0] lru_q;

  cache_state_e           state_q;
  addr_t                  req_addr_q;
  word_t                  req_wdata_q;
  wmask_t                 req_wmask_q;
  logic [IDX_W-1:0]       idx;
  logic [TAG_W-1:0]       tag;
  logic [`CACHE_WAYS-1:0] hit;
  logic                   hit_way;
  logic                   victim;
  logic                   is_write;
  logic                   accept;
  word_t                  line_rd;
  word_t                  merged;

  // Ignore valid while ready for the last request is still up
  assign accept   = (state_q == IDLE) && cpu_valid_i && !cpu_ready_o;
  assign is_write = |req_wmask_q;

  assign idx = req_addr_q[IDX_W+1:2];
  assign tag = req_addr_q[`CACHE_XLEN-1:IDX_W+2];

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit_way = hit[1];
  assign victim  = lru_q[idx];
  assign line_rd = data_q[hit_way][idx];

  // Hit line with the written bytes replaced
  always_comb begin
    merged = line_rd;
    for (int b = 0; b < `CACHE_XLEN/8; b++) begin
      if (req_wmask_q[b]) merged[8*b +: 8] = req_wdata_q[8*b +: 8];
    end
  end

  // Memory port, refill reads and write-through
  assign ram_valid_o = (state_q == REFILL) || (state_q == WRITE);
  assign ram_addr_o  = {req_addr_q[`CACHE_XLEN-1:2], 2'b00};
  assign ram_wdata_o = req_wdata_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= IDLE;
      cpu_ready_o <= 1'b0;
      ram_wmask_o <= '0;
      lru_q       <= '0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      cpu_ready_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) state_q <= LOOKUP;
        end
        LOOKUP: begin
          if (|hit) lru_q[idx] <= ~hit_way;
          if (is_write) begin
            // Writes go to memory on hit and miss alike
            ram_wmask_o <= req_wmask_q;
            state_q     <= WRITE;
          end else if (|hit) begin
            cpu_ready_o <= 1'b1;
            state_q     <= IDLE;
          end else begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (ram_ready_i) begin
            valid_q[victim][idx] <= 1'b1;
            lru_q[idx]           <= ~victim;
            cpu_ready_o          <= 1'b1;
            state_q              <= IDLE;
          end
        end
        WRITE: begin
          if (ram_ready_i) begin
            ram_wmask_o <= '0;
            cpu_ready_o <= 1'b1;
            state_q     <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture, arrays and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q  <= cpu_addr_i;
      req_wdata_q <= cpu_din_i;
      req_wmask_q <= cpu_wmask_i;
    end
    if (state_q == LOOKUP && |hit) begin
      // Write miss leaves the arrays alone
      if (is_write) data_q[hit_way][idx] <= merged;
      else cpu_dout_o <= line_rd;
    end
    if (state_q == REFILL && ram_ready_i) begin
      tag_q[victim][idx]  <= tag;
      data_q[victim][idx] <= ram_rdata_i;
      cpu_dout_o          <= ram_rdata_i;
    end
  end

  // Registered mask must track the WRITE state
  assert property (@(posedge clk) disable iff (rst_i)
    (state_q != WRITE) |-> (ram_wmask_o == '0))
    else $error("dcache ram_wmask_o nonzero outside WRITE");

  // Ready is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst_i)
    cpu_ready_o |=> !cpu_ready_o)
    else $error("dcache cpu_ready_o high two cycles running");

endmodule

`default_nettype wire

//--- hdl/icache.sv
// ====================
// Instruction cache, 2-way set-associative
// One word per line, LRU bit per set, refill on miss
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module icache #(
  parameter int ENTRIES_PER_WAY = `CACHE_ICACHE_SETS
) (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire cache_pkg::addr_t cpu_addr_i,
  input  wire                   cpu_valid_i,
  output cache_pkg::word_t      cpu_dout_o,
  output logic                  cpu_ready_o,
  output cache_pkg::addr_t      ram_addr_o,
  input  wire cache_pkg::word_t ram_rdata_i,
  output logic                  ram_valid_o,
  input  wire                   ram_ready_i
);
  import cache_pkg::*;

  localparam int IDX_W = $clog2(ENTRIES_PER_WAY);
  localparam int TAG_W = `CACHE_XLEN - IDX_W - 2;

  // Tag and data storage per way
  logic [TAG_W-1:0]           tag_q   [`CACHE_WAYS][ENTRIES_PER_WAY];
  word_t                      data_q  [`CACHE_WAYS][ENTRIES_PER_WAY];
  logic [ENTRIES_PER_WAY-1:0] valid_q [`CACHE_WAYS];
  // Per set, the way to replace next
  logic [ENTRIES_PER_WAY-1:0] lru_q;

  cache_state_e           state_q;
  addr_t                  req_addr_q;
  logic [IDX_W-1:0]       idx;
  logic [TAG_W-1:0]       tag;
  logic [`CACHE_WAYS-1:0] hit;
  logic                   hit_way;
  logic                   victim;
  logic                   accept;

  // New request only when not signalling the previous one
  assign accept = (state_q == IDLE) && cpu_valid_i && !cpu_ready_o;

  // Set index and tag of the held request
  assign idx = req_addr_q[IDX_W+1:2];
  assign tag = req_addr_q[`CACHE_XLEN-1:IDX_W+2];

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit_way = hit[1];
  assign victim  = lru_q[idx];

  // Word-aligned refill request
  assign ram_valid_o = (state_q == REFILL);
  assign ram_addr_o  = {req_addr_q[`CACHE_XLEN-1:2], 2'b00};

  // Control state, valid and LRU bits
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= IDLE;
      cpu_ready_o <= 1'b0;
      lru_q       <= '0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      cpu_ready_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) state_q <= LOOKUP;
        end
        LOOKUP: begin
          if (|hit) begin
            // Point away from the way just used
            lru_q[idx]  <= ~hit_way;
            cpu_ready_o <= 1'b1;
            state_q     <= IDLE;
          end else begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (ram_ready_i) begin
            valid_q[victim][idx] <= 1'b1;
            lru_q[idx]           <= ~victim;
            cpu_ready_o          <= 1'b1;
            state_q              <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture, arrays and read data
  always_ff @(posedge clk) begin
    if (accept) req_addr_q <= cpu_addr_i;
    if (state_q == LOOKUP && |hit) cpu_dout_o <= data_q[hit_way][idx];
    if (state_q == REFILL && ram_ready_i) begin
      tag_q[victim][idx]  <= tag;
      data_q[victim][idx] <= ram_rdata_i;
      cpu_dout_o          <= ram_rdata_i;
    end
  end

  // Refill request held until memory answers
  assert property (@(posedge clk) disable iff (rst_i)
    ram_valid_o && !ram_ready_i |=> ram_valid_o)
    else $error("icache dropped ram_valid_o before ram_ready_i");

endmodule

`default_nettype wire

//--- include/cache_defines.svh
// ====================
// Global sizing macros for the split L1 cache
// Word width, default set counts, associativity
// ====================
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Word and byte-address width
`define CACHE_XLEN 32

// Default sets per way for each cache
`define CACHE_ICACHE_SETS 64
`define CACHE_DCACHE_SETS 64

// Associativity, one LRU bit per set assumes two
`define CACHE_WAYS 2

`endif

//--- sim/tb_cache.sv
// ====================
// Testbench for the split L1 cache
// Random stimulus, reference memory copy
// Port checks and per-test report
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache;
  import cache_pkg::*;

  localparam int WORDS   = 1024;
  localparam int TIMEOUT = 100;

  logic   clk;
  logic   rst_i;
  logic   is_instruction_i;
  addr_t  cpu_addr_i;
  word_t  cpu_din_i;
  wmask_t cpu_wmask_i;
  logic   cpu_valid_i;
  word_t  cpu_dout_o;
  logic   cpu_ready_o;
  addr_t  cache_addr_o;
  word_t  cache_din_o;
  wmask_t cache_wmask_o;
  logic   cache_valid_o;
  word_t  cache_dout_i;
  logic   cache_ready_i;

  // Expected memory contents, one entry per word
  word_t       ref_mem [WORDS];
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          test_start;
  int          lat;
  logic        mem_used;
  word_t       rd_data;
  addr_t       addr;
  word_t       wdata;
  wmask_t      mask;

  cache #(
    .ICACHE_ENTRIES_PER_WAY(`CACHE_ICACHE_SETS),
    .DCACHE_ENTRIES_PER_WAY(`CACHE_DCACHE_SETS)
  ) dut (.*);

  tb_mem_model #(
    .WORDS(WORDS)
  ) mem (
    .clk    (clk),
    .rst_i  (rst_i),
    .addr_i (cache_addr_o),
    .din_i  (cache_din_o),
    .wmask_i(cache_wmask_o),
    .valid_i(cache_valid_o),
    .dout_o (cache_dout_i),
    .ready_o(cache_ready_i)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Code in the lower half of the range, data in the upper
  function automatic addr_t code_addr();
    return $urandom_range(WORDS/2 - 1, 0) << 2;
  endfunction

  function automatic addr_t data_addr();
    return $urandom_range(WORDS - 1, WORDS/2) << 2;
  endfunction

  // One CPU request; leaves data, latency and memory activity behind
  task automatic access(input logic instr, input addr_t a, input word_t d, input wmask_t m);
    int   cycles;
    logic done;
    @(negedge clk);
    is_instruction_i = instr;
    cpu_addr_i       = a;
    cpu_din_i        = d;
    cpu_wmask_i      = m;
    cpu_valid_i      = 1'b1;
    mem_used = 1'b0;
    done     = 1'b0;
    cycles   = 0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (cache_valid_o) begin
        mem_used = 1'b1;
        if (cache_addr_o !== {a[31:2], 2'b00}) begin
          $display("[FAIL] cache_addr_o = %h, expected %h", cache_addr_o, {a[31:2], 2'b00});
          err_cnt++;
        end
        // Read refills carry a zero mask
        if (cache_wmask_o !== m) begin
          $display("[FAIL] cache_wmask_o = %h, expected %h", cache_wmask_o, m);
          err_cnt++;
        end
        if (m != '0 && cache_din_o !== d) begin
          $display("[FAIL] cache_din_o = %h, expected %h", cache_din_o, d);
          err_cnt++;
        end
      end else if (instr && cache_wmask_o !== '0) begin
        $display("[FAIL] cache_wmask_o = %h, expected %h", cache_wmask_o, 4'h0);
        err_cnt++;
      end
      if (cpu_ready_o) done = 1'b1;
    end
    if (!done) begin
      $display("Timeout: no cpu_ready_o within %0d cycles for address %h", TIMEOUT, a);
      err_cnt++;
    end
    lat         = cycles;
    rd_data     = cpu_dout_o;
    cpu_valid_i = 1'b0;
    cpu_wmask_i = '0;
  endtask

  task automatic read_check(input logic instr, input addr_t a);
    access(instr, a, '0, '0);
    if (rd_data !== ref_mem[a[11:2]]) begin
      $display("[FAIL] cpu_dout_o = %h, expected %h at %h", rd_data, ref_mem[a[11:2]], a);
      err_cnt++;
    end
  endtask

  // Data write, then merge into the reference copy
  task automatic write_ref(input addr_t a, input word_t d, input wmask_t m);
    access(1'b0, a, d, m);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) ref_mem[a[11:2]][8*b +: 8] = d[8*b +: 8];
    end
  endtask

  task automatic end_test(input int num, input string what);
    if (err_cnt == test_start) begin
      pass_cnt++;
      $display("Test %0d %s: ok", num, what);
    end else begin
      fail_cnt++;
      $display("Test %0d %s: %0d errors", num, what, err_cnt - test_start);
    end
    test_start = err_cnt;
  endtask

  initial begin
    void'($urandom(4682));
    rst_i            = 1'b1;
    is_instruction_i = 1'b0;
    cpu_addr_i       = '0;
    cpu_din_i        = '0;
    cpu_wmask_i      = '0;
    cpu_valid_i      = 1'b0;
    err_cnt          = 0;
    pass_cnt         = 0;
    fail_cnt         = 0;
    test_start       = 0;
    repeat (8) @(negedge clk);
    rst_i = 1'b0;
    // Start from the memory's fill pattern
    for (int i = 0; i < WORDS; i++) begin
      ref_mem[i] = mem.mem_q[i];
    end

    for (int i = 0; i < 32; i++) begin
      read_check(1'b1, code_addr());
    end
    end_test(1, "instruction reads");

    // Repeat read must hit in two cycles with no memory traffic
    for (int i = 0; i < 16; i++) begin
      addr = (i % 2 == 0) ? code_addr() : data_addr();
      read_check(i % 2 == 0, addr);
      read_check(i % 2 == 0, addr);
      if (mem_used || lat != 2) begin
        $display("Repeat read of %h missed: latency %0d, memory used %0b", addr, lat, mem_used);
        err_cnt++;
      end
    end
    end_test(2, "hit path");

    for (int i = 0; i < 24; i++) begin
      addr  = data_addr();
      wdata = $urandom();
      mask  = wmask_t'($urandom_range(15, 1));
      // Warm the line on even passes so the write hits
      if (i % 2 == 0) read_check(1'b0, addr);
      write_ref(addr, wdata, mask);
      read_check(1'b0, addr);
    end
    end_test(3, "masked writes");

    // Port values checked inside each access
    for (int i = 0; i < 16; i++) begin
      write_ref(data_addr(), $urandom(), wmask_t'($urandom_range(15, 1)));
      read_check(1'b1, code_addr());
    end
    end_test(4, "memory port");

    // Set 16 of the instruction cache, tags 0, 1 and 2
    read_check(1'b1, 32'h040);
    read_check(1'b1, 32'h140);
    read_check(1'b1, 32'h040);
    read_check(1'b1, 32'h240);
    read_check(1'b1, 32'h040);
    if (mem_used) begin
      $display("Read of 040 went to memory, LRU evicted the wrong way");
      err_cnt++;
    end
    read_check(1'b1, 32'h140);
    if (!mem_used) begin
      $display("Read of 140 hit although 240 should have evicted it");
      err_cnt++;
    end
    end_test(5, "LRU replacement");

    for (int i = 0; i < 400; i++) begin
      case ($urandom_range(2, 0))
        0: read_check(1'b1, code_addr());
        1: read_check(1'b0, data_addr());
        default: write_ref(data_addr(), $urandom(), wmask_t'($urandom_range(15, 1)));
      endcase
    end
    end_test(6, "random mix");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
// ====================
// Memory responder for the cache testbench
// Word array, masked writes, random ready delay
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter int WORDS = 1024
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire cache_pkg::addr_t  addr_i,
  input  wire cache_pkg::word_t  din_i,
  input  wire cache_pkg::wmask_t wmask_i,
  input  wire                    valid_i,
  output cache_pkg::word_t       dout_o,
  output logic                   ready_o
);
  import cache_pkg::*;

  localparam int AW = $clog2(WORDS);

  word_t         mem_q [WORDS];
  word_t         merged;
  int unsigned   wait_cnt;
  logic          busy;
  logic [AW-1:0] widx;

  // Word index, byte offset ignored
  assign widx = addr_i[AW+1:2];

  // Outputs change on the falling edge only
  always @(negedge clk) begin
    ready_o <= 1'b0;
    if (rst_i) begin
      busy = 1'b0;
      dout_o <= '0;
      for (int i = 0; i < WORDS; i++) begin
        // Odd multiplier keeps every byte address distinct
        mem_q[i] <= (i * 4) * 32'h9e37_79b1 ^ 32'h5a3c_0f17;
      end
    end else if (valid_i && !ready_o) begin
      // New request draws a delay of 1 to 6 cycles
      if (!busy) begin
        busy = 1'b1;
        wait_cnt = $urandom_range(6, 1);
      end
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        busy = 1'b0;
        merged = mem_q[widx];
        for (int b = 0; b < 4; b++) begin
          if (wmask_i[b]) merged[8*b +: 8] = din_i[8*b +: 8];
        end
        mem_q[widx] <= merged;
        dout_o      <= mem_q[widx];
        ready_o     <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/cache.sv
sim/tb_mem_model.sv
sim/tb_cache.sv
